/* sources.f */
+incdir+logic
logic/perf_pkg.sv
logic/commit_event_decoder.sv
logic/hpm_counter_bank.sv
logic/apb_hpm_slave.sv
logic/perf_monitor_top.sv
verification/perf_monitor_tb.sv

/* Makefile */
TOP = perf_monitor_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* verification/perf_monitor_tb.sv */
/*
 * Performance monitor testbench
 * Table-driven APB and event stimulus, checked against a counter model
 */
`timescale 1ns/1ps
`default_nettype none

`include "perf_consts.svh"

module perf_monitor_tb;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_SWEEP, OP_PULSE, OP_RAND, OP_DBG} op_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] data;    // Write data, event pattern or debug level
    logic [7:0]  cycles;
    logic [31:0] exp;
    logic        err;
  } step_t;

  // Port 0 in [9:0], port 1 in [19:10], strobes from bit 20
  localparam logic [31:0] st_dcache = 32'h0020_0000;
  localparam logic [9:0] rec_load      = {1'b1, perf_pkg::LOAD, 1'b0, 5'd7};
  localparam logic [9:0] rec_load_nack = {1'b0, perf_pkg::LOAD, 1'b0, 5'd7};
  localparam logic [9:0] rec_call      = {1'b1, perf_pkg::CTRL, 1'b1, 5'd1};
  localparam logic [9:0] rec_call5     = {1'b1, perf_pkg::CTRL, 1'b1, 5'd5};
  localparam logic [9:0] rec_ret       = {1'b1, perf_pkg::CTRL, 1'b1, 5'd0};
  localparam logic [9:0] rec_ret_nack  = {1'b0, perf_pkg::CTRL, 1'b1, 5'd0};

  logic clk_i = 1'b0;
  logic rst_ni;
  perf_pkg::commit_rec_t [`PERF_COMMIT_PORTS-1:0] commit_i;
  logic icache_miss_i;
  logic dcache_miss_i;
  logic itlb_miss_i;
  logic dtlb_miss_i;
  logic exception_i;
  logic mispredict_i;
  logic debug_mode_i;
  logic psel_i;
  logic penable_i;
  logic pwrite_i;
  logic [`PERF_APB_AW-1:0] paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic pready_o;
  logic pslverr_o;

  // Reference model state
  logic [63:0] cnt_m [`PERF_NUM_CNT];
  logic [3:0]  sel_m [`PERF_NUM_CNT];
  logic [3:0]  inh_m;
  logic        dbg_m;

  step_t  steps[$];
  integer seed = 57095;
  int     errors = 0;
  int     checks = 0;

  perf_monitor_top DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .commit_i      (commit_i),
    .icache_miss_i (icache_miss_i),
    .dcache_miss_i (dcache_miss_i),
    .itlb_miss_i   (itlb_miss_i),
    .dtlb_miss_i   (dtlb_miss_i),
    .exception_i   (exception_i),
    .mispredict_i  (mispredict_i),
    .debug_mode_i  (debug_mode_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] ports(input logic [9:0] p1, input logic [9:0] p0);
    return {12'd0, p1, p0};
  endfunction

  // Bit n set when event id n fires for the pattern
  function automatic logic [15:0] event_ids(input logic [31:0] pat);
    logic [15:0] ev;
    logic [9:0]  rec;
    logic [2:0]  fu;
    ev     = '0;
    ev[1]  = pat[20];
    ev[2]  = pat[21];
    ev[3]  = pat[22];
    ev[4]  = pat[23];
    ev[12] = pat[24];
    ev[13] = pat[25];
    for (int p = 0; p < `PERF_COMMIT_PORTS; p++) begin
      rec = pat[10*p +: 10];
      fu  = rec[8:6];
      ev[5]  |= rec[9] && (fu == perf_pkg::LOAD);
      ev[6]  |= rec[9] && (fu == perf_pkg::STORE);
      ev[7]  |= rec[9] && (fu == perf_pkg::CTRL);
      ev[8]  |= (fu == perf_pkg::CTRL) && rec[5] && ((rec[4:0] == 5'd1) || (rec[4:0] == 5'd5));
      ev[9]  |= rec[5] && (rec[4:0] == 5'd0);  // Ack not required
      ev[10] |= (fu == perf_pkg::ALU) || (fu == perf_pkg::MULT);
      ev[11] |= rec[9] && (fu == perf_pkg::FPU);
    end
    return ev;
  endfunction

  task automatic model_count(input logic [31:0] pat);
    logic [15:0] ev;
    ev = event_ids(pat);
    for (int k = 0; k < `PERF_NUM_CNT; k++) begin
      if (ev[sel_m[k]] && !inh_m[k] && !dbg_m) begin
        cnt_m[k] = cnt_m[k] + 64'd1;
      end
    end
  endtask

  task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
    if ((addr[1:0] != 2'b00) || (addr > `PERF_ADDR_INHIBIT)) begin
      return;  // Unmapped writes are dropped
    end
    if (addr < `PERF_ADDR_EVT_BASE) begin
      if (addr[2]) begin
        cnt_m[addr[4:3]][63:32] = data;
      end else begin
        cnt_m[addr[4:3]][31:0] = data;
      end
    end else if (addr < `PERF_ADDR_INHIBIT) begin
      sel_m[addr[3:2]] = data[3:0];
    end else begin
      inh_m = data[3:0];
    end
  endtask

  function automatic logic [31:0] model_word(input logic [7:0] addr);
    if ((addr[1:0] != 2'b00) || (addr > `PERF_ADDR_INHIBIT)) begin
      return '0;
    end
    if (addr < `PERF_ADDR_EVT_BASE) begin
      return addr[2] ? cnt_m[addr[4:3]][63:32] : cnt_m[addr[4:3]][31:0];
    end
    if (addr < `PERF_ADDR_INHIBIT) begin
      return {28'd0, sel_m[addr[3:2]]};
    end
    return {28'd0, inh_m};
  endfunction

  task automatic check(input logic [31:0] exp, input logic [31:0] got, input string msg);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("[FAIL] %0t ns: %s, expected %h, got %h", $time, msg, exp, got);
    end
  endtask

  task automatic drive_events(input logic [31:0] pat);
    commit_i      = pat[19:0];
    icache_miss_i = pat[20];
    dcache_miss_i = pat[21];
    itlb_miss_i   = pat[22];
    dtlb_miss_i   = pat[23];
    exception_i   = pat[24];
    mispredict_i  = pat[25];
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    #2;  // Sample mid access cycle
    while (!pready_o) begin
      if (n == 16) begin
        $display("Timeout: pready did not rise within 16 cycles");
        $display("TB FAILED");
        $finish;
      end
      n++;
      @(posedge clk_i);
      #3;
    end
  endtask

  task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    wait_ready();
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);  // Write lands on this edge
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // Idle tail lets the last event reach its counter
  task automatic run_events(input logic [31:0] pat, input logic [7:0] cycles, input logic rnd);
    logic [31:0] p;
    for (int c = 0; c < int'(cycles); c++) begin
      p = rnd ? ($random(seed) & 32'h03FF_FFFF) : pat;
      @(posedge clk_i);
      #1;
      drive_events(p);
      model_count(p);
    end
    @(posedge clk_i);
    #1;
    drive_events('0);
    @(posedge clk_i);
  endtask

  task automatic check_all_words();
    logic [7:0]  a;
    logic [31:0] rd;
    logic        err;
    for (int i = 0; i <= int'(`PERF_ADDR_INHIBIT) / 4; i++) begin
      a = 8'(i * 4);
      apb_xfer(1'b0, a, 32'd0, rd, err);
      check(model_word(a), rd, $sformatf("word 0x%h vs model", a));
      check(32'd0, {31'd0, err}, $sformatf("pslverr on word 0x%h", a));
    end
  endtask

  task automatic add_step(input op_e op, input int addr, input int data, input int cycles,
                          input int exp, input int err);
    step_t s;
    s.op     = op;
    s.addr   = 8'(addr);
    s.data   = data;
    s.cycles = 8'(cycles);
    s.exp    = exp;
    s.err    = err[0];
    steps.push_back(s);
  endtask

  task automatic build_table();
    add_step(OP_SWEEP, 0, 0, 0, 0, 0);  // All zero after reset
    // Dcache miss, load, call, return
    add_step(OP_WR, 'h20, 2, 0, 0, 0);
    add_step(OP_WR, 'h24, 5, 0, 0, 0);
    add_step(OP_WR, 'h28, 8, 0, 0, 0);
    add_step(OP_WR, 'h2C, 9, 0, 0, 0);
    add_step(OP_RD, 'h24, 0, 0, 5, 0);
    add_step(OP_PULSE, 0, ports(rec_load, rec_load) | st_dcache, 3, 0, 0);
    add_step(OP_PULSE, 0, ports(rec_ret, rec_call), 2, 0, 0);
    add_step(OP_PULSE, 0, ports(rec_ret_nack, rec_load_nack), 4, 0, 0);
    add_step(OP_PULSE, 0, ports(10'd0, rec_call5), 1, 0, 0);
    add_step(OP_RD, 'h00, 0, 0, 3, 0);
    add_step(OP_RD, 'h08, 0, 0, 3, 0);  // Both ports count once
    add_step(OP_RD, 'h10, 0, 0, 3, 0);
    add_step(OP_RD, 'h18, 0, 0, 6, 0);
    add_step(OP_RD, 'h1C, 0, 0, 0, 0);
    // High word write, low word carry
    add_step(OP_WR, 'h04, 'hDEAD_0001, 0, 0, 0);
    add_step(OP_RD, 'h04, 0, 0, 'hDEAD_0001, 0);
    add_step(OP_WR, 'h00, 'hFFFF_FFFE, 0, 0, 0);
    add_step(OP_PULSE, 0, st_dcache, 3, 0, 0);
    add_step(OP_RD, 'h00, 0, 0, 1, 0);
    add_step(OP_RD, 'h04, 0, 0, 'hDEAD_0002, 0);
    // Inhibit counter 1, then debug freeze
    add_step(OP_WR, 'h30, 2, 0, 0, 0);
    add_step(OP_RD, 'h30, 0, 0, 2, 0);
    add_step(OP_PULSE, 0, ports(10'd0, rec_load) | st_dcache, 2, 0, 0);
    add_step(OP_RD, 'h00, 0, 0, 3, 0);
    add_step(OP_RD, 'h08, 0, 0, 3, 0);
    add_step(OP_WR, 'h30, 0, 0, 0, 0);
    add_step(OP_DBG, 0, 1, 0, 0, 0);
    add_step(OP_PULSE, 0, ports(rec_call, rec_load) | st_dcache, 3, 0, 0);
    add_step(OP_DBG, 0, 0, 0, 0, 0);
    add_step(OP_RD, 'h00, 0, 0, 3, 0);
    add_step(OP_RD, 'h08, 0, 0, 3, 0);
    add_step(OP_RD, 'h10, 0, 0, 3, 0);
    add_step(OP_PULSE, 0, ports(10'd0, rec_load), 1, 0, 0);
    add_step(OP_RD, 'h08, 0, 0, 4, 0);
    add_step(OP_SWEEP, 0, 0, 0, 0, 0);
    // Random traffic with two select sets
    add_step(OP_WR, 'h20, 1, 0, 0, 0);
    add_step(OP_WR, 'h24, 10, 0, 0, 0);
    add_step(OP_WR, 'h28, 13, 0, 0, 0);
    add_step(OP_WR, 'h2C, 7, 0, 0, 0);
    add_step(OP_RAND, 0, 0, 48, 0, 0);
    add_step(OP_SWEEP, 0, 0, 0, 0, 0);
    add_step(OP_WR, 'h20, 4, 0, 0, 0);
    add_step(OP_WR, 'h24, 6, 0, 0, 0);
    add_step(OP_WR, 'h28, 14, 0, 0, 0);  // Reserved code
    add_step(OP_WR, 'h2C, 11, 0, 0, 0);
    add_step(OP_WR, 'h30, 1, 0, 0, 0);
    add_step(OP_RAND, 0, 0, 48, 0, 0);
    add_step(OP_SWEEP, 0, 0, 0, 0, 0);
    // Unmapped and misaligned accesses
    add_step(OP_RD, 'h34, 0, 0, 0, 1);
    add_step(OP_RD, 'h02, 0, 0, 0, 1);
    add_step(OP_RD, 'hFC, 0, 0, 0, 1);
    add_step(OP_RD, 'h44, 0, 0, 0, 1);  // Same word index as counter 0 high
    add_step(OP_WR, 'h34, 'hFFFF_FFFF, 0, 0, 1);
    add_step(OP_WR, 'h21, 5, 0, 0, 1);
    add_step(OP_WR, 'h32, 'hF, 0, 0, 1);
    add_step(OP_WR, 'h40, 'hFFFF_FFFF, 0, 0, 1);
    add_step(OP_SWEEP, 0, 0, 0, 0, 0);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    rst_ni       = 1'b0;
    debug_mode_i = 1'b0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    drive_events('0);
    for (int k = 0; k < `PERF_NUM_CNT; k++) begin
      cnt_m[k] = '0;
      sel_m[k] = '0;
    end
    inh_m = '0;
    dbg_m = 1'b0;
    build_table();

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check(32'd0, {30'd0, pready_o, pslverr_o}, "pready and pslverr after reset");

    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WR: begin
          apb_xfer(1'b1, steps[i].addr, steps[i].data, rd, err);
          check({31'd0, steps[i].err}, {31'd0, err},
                $sformatf("step %0d pslverr on write 0x%h", i, steps[i].addr));
          model_write(steps[i].addr, steps[i].data);
        end
        OP_RD: begin
          apb_xfer(1'b0, steps[i].addr, 32'd0, rd, err);
          check(steps[i].exp, rd, $sformatf("step %0d read 0x%h", i, steps[i].addr));
          check({31'd0, steps[i].err}, {31'd0, err},
                $sformatf("step %0d pslverr on read 0x%h", i, steps[i].addr));
        end
        OP_SWEEP: check_all_words();
        OP_PULSE: run_events(steps[i].data, steps[i].cycles, 1'b0);
        OP_RAND:  run_events(32'd0, steps[i].cycles, 1'b1);
        OP_DBG: begin
          @(posedge clk_i);
          #1;
          debug_mode_i = steps[i].data[0];
          dbg_m        = steps[i].data[0];
        end
        default: ;
      endcase
    end

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/perf_monitor_top.sv */
/*
 * Performance monitor top level
 * Event decoder, counter bank and APB slave
 */
`timescale 1ns/1ps
`default_nettype none

`include "perf_consts.svh"

module perf_monitor_top (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  perf_pkg::commit_rec_t [`PERF_COMMIT_PORTS-1:0] commit_i,
  input  logic                                           icache_miss_i,
  input  logic                                           dcache_miss_i,
  input  logic                                           itlb_miss_i,
  input  logic                                           dtlb_miss_i,
  input  logic                                           exception_i,
  input  logic                                           mispredict_i,
  input  logic                                           debug_mode_i,
  input  logic                                           psel_i,
  input  logic                                           penable_i,
  input  logic                                           pwrite_i,
  input  logic [`PERF_APB_AW-1:0]                        paddr_i,
  input  logic [31:0]                                    pwdata_i,
  output logic [31:0]                                    prdata_o,
  output logic                                           pready_o,
  output logic                                           pslverr_o
);

  perf_pkg::event_vec_t            evt_q;
  logic                            wr_en;
  logic                            rd_en;
  logic [`PERF_REG_IDX_W-1:0]      reg_sel;
  logic [`PERF_DATA_W-1:0]         wdata;
  logic [`PERF_DATA_W-1:0]         rdata;
  logic                            invalid;

  commit_event_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .commit_i      (commit_i),
    .icache_miss_i (icache_miss_i),
    .dcache_miss_i (dcache_miss_i),
    .itlb_miss_i   (itlb_miss_i),
    .dtlb_miss_i   (dtlb_miss_i),
    .exception_i   (exception_i),
    .mispredict_i  (mispredict_i),
    .evt_o         (evt_q)
  );

  hpm_counter_bank u_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .evt_i        (evt_q),
    .debug_mode_i (debug_mode_i),
    .wr_en_i      (wr_en),
    .rd_en_i      (rd_en),
    .reg_sel_i    (reg_sel),
    .wdata_i      (wdata),
    .rdata_o      (rdata),
    .invalid_o    (invalid)
  );

  apb_hpm_slave u_apb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .wr_en_o   (wr_en),
    .rd_en_o   (rd_en),
    .reg_sel_o (reg_sel),
    .wdata_o   (wdata),
    .rdata_i   (rdata),
    .invalid_i (invalid)
  );

endmodule

`default_nettype wire

/* logic/apb_hpm_slave.sv */
/*
 * APB slave for the HPM counter bank
 * Zero-wait access, word index decode and error response
 */
`timescale 1ns/1ps
`default_nettype none

`include "perf_consts.svh"

module apb_hpm_slave (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [`PERF_APB_AW-1:0]       paddr_i,
  input  logic [`PERF_DATA_W-1:0]       pwdata_i,
  output logic [`PERF_DATA_W-1:0]       prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  output logic                          wr_en_o,
  output logic                          rd_en_o,
  output logic [`PERF_REG_IDX_W-1:0]    reg_sel_o,
  output logic [`PERF_DATA_W-1:0]       wdata_o,
  input  logic [`PERF_DATA_W-1:0]       rdata_i,
  input  logic                          invalid_i
);

  logic setup;
  logic access;
  logic misaligned;
  logic out_of_range;
  logic addr_err;
  logic err_q;

  assign setup  = psel_i && !penable_i;
  assign access = psel_i && penable_i;

  // Address checks
  assign misaligned   = paddr_i[1:0] != 2'b00;
  assign out_of_range = |paddr_i[`PERF_APB_AW-1:`PERF_REG_IDX_W+2];  // Above the word index
  assign addr_err     = misaligned || out_of_range || invalid_i;

  assign reg_sel_o = paddr_i[`PERF_REG_IDX_W+1:2];  // Byte to word index
  assign wdata_o   = pwdata_i;

  // A bad address never reaches the bank
  assign wr_en_o = access && pwrite_i && !addr_err;
  assign rd_en_o = access && !pwrite_i && !addr_err;

  // Bank drives zero when not read
  assign prdata_o  = rdata_i;
  assign pready_o  = access;
  assign pslverr_o = access && err_q;

  // Error latched in setup, shown in the access cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= setup && addr_err;
    end
  end

  penable_needs_psel_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i);

  // Setup is followed by an access with the same request
  psel_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    setup |=> access && $stable(paddr_i) && $stable(pwrite_i));

endmodule

`default_nettype wire

/* logic/hpm_counter_bank.sv */
/*
 * HPM counter bank
 * Four 64-bit event counters with selects, inhibit and 32-bit word access
 */
`timescale 1ns/1ps
`default_nettype none

`include "perf_consts.svh"

module hpm_counter_bank (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  perf_pkg::event_vec_t          evt_i,
  input  logic                          debug_mode_i,
  input  logic                          wr_en_i,
  input  logic                          rd_en_i,
  input  logic [3:0]                    reg_sel_i,
  input  logic [`PERF_DATA_W-1:0]       wdata_i,
  output logic [`PERF_DATA_W-1:0]       rdata_o,
  output logic                          invalid_o
);

  // Word index bases derived from the byte map
  localparam int unsigned cnt_idx_base = `PERF_ADDR_CNT_BASE / 4;
  localparam int unsigned evt_idx_base = `PERF_ADDR_EVT_BASE / 4;
  localparam int unsigned inh_idx      = `PERF_ADDR_INHIBIT / 4;

  logic [`PERF_CNT_W-1:0]   cnt_q [`PERF_NUM_CNT];
  perf_pkg::event_id_e      sel_q [`PERF_NUM_CNT];
  logic [`PERF_NUM_CNT-1:0] inhibit_q;
  logic [`PERF_NUM_CNT-1:0] evt_hit;
  logic [`PERF_NUM_CNT-1:0] inc;

  logic [3:0] cnt_off;
  logic [3:0] sel_off;
  logic       is_cnt;
  logic       is_sel;
  logic       is_inh;
  logic [1:0] cnt_k;
  logic       cnt_hi;
  logic [1:0] sel_k;

  // Word index decode
  always_comb begin
    cnt_off   = reg_sel_i - 4'(cnt_idx_base);
    sel_off   = reg_sel_i - 4'(evt_idx_base);
    is_cnt    = cnt_off < 4'(2 * `PERF_NUM_CNT);
    is_sel    = sel_off < 4'(`PERF_NUM_CNT);
    is_inh    = reg_sel_i == 4'(inh_idx);
    cnt_k     = cnt_off[2:1];
    cnt_hi    = cnt_off[0];  // Odd word is the high half
    sel_k     = sel_off[1:0];
    invalid_o = !(is_cnt || is_sel || is_inh);
  end

  always_comb begin
    for (int k = 0; k < `PERF_NUM_CNT; k++) begin
      case (sel_q[k])
        perf_pkg::EVT_ICACHE_MISS: evt_hit[k] = evt_i.icache_miss;
        perf_pkg::EVT_DCACHE_MISS: evt_hit[k] = evt_i.dcache_miss;
        perf_pkg::EVT_ITLB_MISS:   evt_hit[k] = evt_i.itlb_miss;
        perf_pkg::EVT_DTLB_MISS:   evt_hit[k] = evt_i.dtlb_miss;
        perf_pkg::EVT_LOAD:        evt_hit[k] = evt_i.load;
        perf_pkg::EVT_STORE:       evt_hit[k] = evt_i.store;
        perf_pkg::EVT_BRANCH:      evt_hit[k] = evt_i.branch;
        perf_pkg::EVT_CALL:        evt_hit[k] = evt_i.call;
        perf_pkg::EVT_RETURN:      evt_hit[k] = evt_i.ret;
        perf_pkg::EVT_INTEGER:     evt_hit[k] = evt_i.int_op;
        perf_pkg::EVT_FLOAT:       evt_hit[k] = evt_i.float_op;
        perf_pkg::EVT_EXCEPTION:   evt_hit[k] = evt_i.exception_evt;
        perf_pkg::EVT_MISPREDICT:  evt_hit[k] = evt_i.mispredict;
        default:                   evt_hit[k] = 1'b0;  // Off and reserved
      endcase
      // Any register write freezes counting for that cycle
      inc[k] = evt_hit[k] && !inhibit_q[k] && !debug_mode_i && !wr_en_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rd_en_i) begin
      if (is_cnt) begin
        rdata_o = cnt_hi ? cnt_q[cnt_k][63:32] : cnt_q[cnt_k][31:0];
      end else if (is_sel) begin
        rdata_o = `PERF_DATA_W'(sel_q[sel_k]);
      end else if (is_inh) begin
        rdata_o = `PERF_DATA_W'(inhibit_q);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < `PERF_NUM_CNT; k++) begin
        cnt_q[k] <= '0;
        sel_q[k] <= perf_pkg::EVT_OFF;
      end
      inhibit_q <= '0;
    end else begin
      for (int k = 0; k < `PERF_NUM_CNT; k++) begin
        if (wr_en_i && is_cnt && (cnt_k == 2'(k))) begin
          if (cnt_hi) begin
            cnt_q[k][63:32] <= wdata_i;
          end else begin
            cnt_q[k][31:0] <= wdata_i;
          end
        end else if (inc[k]) begin
          cnt_q[k] <= cnt_q[k] + 64'd1;
        end
        if (wr_en_i && is_sel && (sel_k == 2'(k))) begin
          sel_q[k] <= perf_pkg::event_id_e'(wdata_i[3:0]);
        end
      end
      if (wr_en_i && is_inh) begin
        inhibit_q <= wdata_i[`PERF_NUM_CNT-1:0];
      end
    end
  end

  // Without a write a counter holds or steps by one
  for (genvar k = 0; k < `PERF_NUM_CNT; k++) begin : g_cnt_step
    cnt_step_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !wr_en_i |=> (cnt_q[k] == $past(cnt_q[k])) || (cnt_q[k] == $past(cnt_q[k]) + 64'd1));
  end

endmodule

`default_nettype wire

/* logic/commit_event_decoder.sv */
/*
 * Commit event decoder
 * Classifies commit records and raw miss strobes into a registered event vector
 */
`timescale 1ns/1ps
`default_nettype none

`include "perf_consts.svh"

module commit_event_decoder (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  perf_pkg::commit_rec_t [`PERF_COMMIT_PORTS-1:0] commit_i,
  input  logic                                           icache_miss_i,
  input  logic                                           dcache_miss_i,
  input  logic                                           itlb_miss_i,
  input  logic                                           dtlb_miss_i,
  input  logic                                           exception_i,
  input  logic                                           mispredict_i,
  output perf_pkg::event_vec_t                           evt_o
);

  // Per-port classification
  logic [`PERF_COMMIT_PORTS-1:0] load_p;
  logic [`PERF_COMMIT_PORTS-1:0] store_p;
  logic [`PERF_COMMIT_PORTS-1:0] branch_p;
  logic [`PERF_COMMIT_PORTS-1:0] call_p;
  logic [`PERF_COMMIT_PORTS-1:0] ret_p;
  logic [`PERF_COMMIT_PORTS-1:0] int_p;
  logic [`PERF_COMMIT_PORTS-1:0] fp_p;

  perf_pkg::event_vec_t evt_d;
  perf_pkg::event_vec_t evt_q;

  always_comb begin
    for (int p = 0; p < `PERF_COMMIT_PORTS; p++) begin
      load_p[p]   = commit_i[p].ack && (commit_i[p].fu == perf_pkg::LOAD);
      store_p[p]  = commit_i[p].ack && (commit_i[p].fu == perf_pkg::STORE);
      branch_p[p] = commit_i[p].ack && (commit_i[p].fu == perf_pkg::CTRL);
      fp_p[p]     = commit_i[p].ack && (commit_i[p].fu == perf_pkg::FPU);
      int_p[p]    = (commit_i[p].fu == perf_pkg::ALU) || (commit_i[p].fu == perf_pkg::MULT);
      // Link register x1 or x5 marks a call
      call_p[p]   = (commit_i[p].fu == perf_pkg::CTRL) && commit_i[p].is_jalr &&
                    ((commit_i[p].rd == 5'd1) || (commit_i[p].rd == 5'd5));
      ret_p[p]    = commit_i[p].is_jalr && (commit_i[p].rd == 5'd0);  // jalr x0, ra
    end
  end

  always_comb begin
    evt_d.icache_miss   = icache_miss_i;
    evt_d.dcache_miss   = dcache_miss_i;
    evt_d.itlb_miss     = itlb_miss_i;
    evt_d.dtlb_miss     = dtlb_miss_i;
    evt_d.load          = |load_p;  // Any port
    evt_d.store         = |store_p;
    evt_d.branch        = |branch_p;
    evt_d.call          = |call_p;
    evt_d.ret           = |ret_p;
    evt_d.int_op        = |int_p;
    evt_d.float_op      = |fp_p;
    evt_d.exception_evt = exception_i;
    evt_d.mispredict    = mispredict_i;
  end

  // Strobes and commit events share one register stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q <= '0;
    end else begin
      evt_q <= evt_d;
    end
  end

  assign evt_o = evt_q;

endmodule

`default_nettype wire

/* logic/perf_pkg.sv */
/*
 * Performance monitor types
 * Event select codes, functional units, commit record and event vector
 */
`default_nettype none

package perf_pkg;

  // Functional unit of a committed instruction
  typedef enum logic [2:0] {
    NONE  = 3'd0,
    ALU   = 3'd1,
    MULT  = 3'd2,
    LOAD  = 3'd3,
    STORE = 3'd4,
    CTRL  = 3'd5,
    FPU   = 3'd6
  } fu_e;

  // Event select codes, 14 and 15 count nothing
  typedef enum logic [3:0] {
    EVT_OFF         = 4'd0,
    EVT_ICACHE_MISS = 4'd1,
    EVT_DCACHE_MISS = 4'd2,
    EVT_ITLB_MISS   = 4'd3,
    EVT_DTLB_MISS   = 4'd4,
    EVT_LOAD        = 4'd5,
    EVT_STORE       = 4'd6,
    EVT_BRANCH      = 4'd7,
    EVT_CALL        = 4'd8,
    EVT_RETURN      = 4'd9,
    EVT_INTEGER     = 4'd10,
    EVT_FLOAT       = 4'd11,
    EVT_EXCEPTION   = 4'd12,
    EVT_MISPREDICT  = 4'd13,
    EVT_RSVD14      = 4'd14,
    EVT_RSVD15      = 4'd15
  } event_id_e;

  typedef struct packed {
    logic       ack;
    fu_e        fu;
    logic       is_jalr;
    logic [4:0] rd;
  } commit_rec_t;

  // Bit id-1 holds event id, so mispredict is the MSB
  typedef struct packed {
    logic mispredict;
    logic exception_evt;
    logic float_op;
    logic int_op;
    logic ret;
    logic call;
    logic branch;
    logic store;
    logic load;
    logic dtlb_miss;
    logic itlb_miss;
    logic dcache_miss;
    logic icache_miss;
  } event_vec_t;

endpackage

`default_nettype wire

/* logic/perf_consts.svh */
/*
 * Performance monitor constants
 * Counter and port counts, APB register offsets and word widths
 */
`ifndef PERF_CONSTS_SVH
`define PERF_CONSTS_SVH

// Bank size and commit width
`define PERF_NUM_CNT       4
`define PERF_COMMIT_PORTS  2

// APB byte offsets
`define PERF_ADDR_CNT_BASE 8'h00  // Counter k low at 8k, high at 8k+4
`define PERF_ADDR_EVT_BASE 8'h20  // Select k at 0x20+4k
`define PERF_ADDR_INHIBIT  8'h30

// Widths
`define PERF_APB_AW        8
`define PERF_DATA_W        32
`define PERF_CNT_W         64
`define PERF_REG_IDX_W     4   // Word index carried from the APB slave to the bank

`endif
